/* hdl/geo_scan_pkg.sv */
// Shared widths, types, stage codes and timing constants, imported by every scanner block
`default_nettype none

package geo_scan_pkg;

    // ----------------------------------------------------------------------
    // Value types
    // ----------------------------------------------------------------------
    typedef logic [15:0] cylinder_t;    // Cylinder number
    typedef logic [3:0]  head_t;        // Physical head number
    typedef logic [4:0]  head_count_t;  // 0..16 heads
    typedef logic [7:0]  sector_t;      // Sector number or sector count

    // Stage reported on scan_stage
    typedef enum logic [2:0] {
        STAGE_IDLE       = 3'd0,
        STAGE_HEAD_SCAN  = 3'd1,  // Probing heads on cylinder 0
        STAGE_SPT_SCAN   = 3'd2,  // Sector range on head 0
        STAGE_CYL_SEARCH = 3'd3,  // Binary search over seek targets
        STAGE_COMPLETE   = 3'd4,
        STAGE_ERROR      = 3'd5
    } scan_stage_e;

    // ----------------------------------------------------------------------
    // Search limits
    // ----------------------------------------------------------------------
    localparam int        MAX_HEADS     = 16;        // Heads probed on cylinder 0
    localparam cylinder_t MAX_CYLINDERS = 16'd4096;  // Exclusive top of the search

    // Timing, all in clk cycles
    localparam int SEEK_TIMEOUT_CYCLES  = 2048;  // Longest wait for seek_done
    localparam int SETTLE_CYCLES        = 16;    // Head settle after positioning
    localparam int TRACK_TIMEOUT_CYCLES = 8192;  // Track read ends here if index stops
    localparam int ROTATIONS_PER_READ   = 2;     // Index edges per track read

    // Counter widths
    localparam int POS_CNT_W   = $clog2(SEEK_TIMEOUT_CYCLES);  // Also covers settle
    localparam int TRACK_CNT_W = $clog2(TRACK_TIMEOUT_CYCLES);
    localparam int ROT_CNT_W   = $clog2(ROTATIONS_PER_READ + 1);

endpackage

`default_nettype wire

/* hdl/position_if.sv */
// Seek plus head select request and its result, passed from sequencer to positioner
`default_nettype none

interface position_if import geo_scan_pkg::*; ();

    logic      req;       // One-cycle pulse
    cylinder_t cylinder;  // Seek target
    head_t     head;      // Head to select
    logic      done;      // Exactly one pulse per req
    logic      error;     // Seek refused or timed out, valid with done

    modport sequencer (
        output req, cylinder, head,
        input  done, error
    );

    modport positioner (
        input  req, cylinder, head,
        output done, error
    );

endinterface

`default_nettype wire

/* hdl/track_probe_if.sv */
// Track read request and its header tallies, passed from sequencer to track reader
`default_nettype none

interface track_probe_if import geo_scan_pkg::*; ();

    logic      start;        // One-cycle pulse
    cylinder_t cylinder;     // Header cylinder to match
    head_t     head;         // Header head to match
    logic      done;         // Pulse at end of read

    // Tallies, valid with done and held until the next start
    sector_t   match_count;  // Saturates at 255
    sector_t   min_sector;
    sector_t   max_sector;

    modport sequencer (
        output start, cylinder, head,
        input  done, match_count, min_sector, max_sector
    );

    modport reader (
        input  start, cylinder, head,
        output done, match_count, min_sector, max_sector
    );

endinterface

`default_nettype wire

/* hdl/head_positioner.sv */
// Runs one seek and head select per request, then waits out the seek and the head settle
`default_nettype none

module head_positioner import geo_scan_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    position_if.positioner pos,
    output logic           seek_start,
    output cylinder_t      seek_cylinder,
    output head_t          head_select,
    input  logic           seek_done,
    input  logic           seek_error
);

    typedef enum logic [1:0] {
        POS_IDLE,
        POS_SEEK,    // seek_start high here
        POS_WAIT,    // Waiting on the seek controller
        POS_SETTLE
    } pos_state_e;

    pos_state_e           state;
    logic [POS_CNT_W-1:0] count;  // Seek timeout, then settle delay

    assign seek_start = (state == POS_SEEK);  // Cycle after req

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= POS_IDLE;
            count         <= '0;
            seek_cylinder <= '0;
            head_select   <= '0;
            pos.done      <= 1'b0;
            pos.error     <= 1'b0;
        end else begin
            pos.done <= 1'b0;
            case (state)
                POS_IDLE: begin
                    if (pos.req) begin
                        seek_cylinder <= pos.cylinder;
                        head_select   <= pos.head;  // Head switches with the seek
                        state         <= POS_SEEK;
                    end
                end
                POS_SEEK: begin
                    count <= '0;
                    state <= POS_WAIT;
                end
                POS_WAIT: begin
                    count <= count + 1'b1;
                    if (seek_error || count == POS_CNT_W'(SEEK_TIMEOUT_CYCLES - 1)) begin
                        pos.done  <= 1'b1;  // Fail at once
                        pos.error <= 1'b1;
                        state     <= POS_IDLE;
                    end else if (seek_done) begin
                        count <= '0;
                        state <= POS_SETTLE;
                    end
                end
                POS_SETTLE: begin
                    count <= count + 1'b1;
                    if (count == POS_CNT_W'(SETTLE_CYCLES - 1)) begin
                        pos.done  <= 1'b1;
                        pos.error <= 1'b0;
                        state     <= POS_IDLE;
                    end
                end
                default: state <= POS_IDLE;
            endcase
        end
    end

    // A request arriving mid seek would be dropped
    assert property (@(posedge clk) disable iff (reset) pos.req |-> state == POS_IDLE)
        else $error("position request arrived while a seek is running");

endmodule

`default_nettype wire

/* hdl/track_reader.sv */
// Counts matching sector headers and their number range over two index rotations per read
`default_nettype none

module track_reader import geo_scan_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    track_probe_if.reader  probe,
    input  logic           sector_header_valid,
    input  logic           sector_crc_ok,
    input  cylinder_t      sector_cylinder,
    input  head_t          sector_head,
    input  sector_t        sector_number,
    input  logic           index_pulse
);

    logic                   busy;        // Read in progress
    logic                   index_prev;
    logic                   index_edge;
    logic                   header_hit;  // Good header for this probe
    logic [ROT_CNT_W-1:0]   rotations;
    logic [TRACK_CNT_W-1:0] timer;       // Guards against a dead index

    assign index_edge = index_pulse && !index_prev;
    assign header_hit = sector_header_valid && sector_crc_ok
                        && sector_cylinder == probe.cylinder
                        && sector_head == probe.head;

    // ----------------------------------------------------------------------
    // Read control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            index_prev <= 1'b0;
            rotations  <= '0;
            timer      <= '0;
            probe.done <= 1'b0;
        end else begin
            index_prev <= index_pulse;  // Tracked while idle too
            probe.done <= 1'b0;
            if (probe.start) begin
                busy      <= 1'b1;
                rotations <= '0;
                timer     <= '0;
            end else if (busy) begin
                timer <= timer + 1'b1;
                if (index_edge)
                    rotations <= rotations + 1'b1;
                // Done lands the cycle after the last index edge
                if ((index_edge && rotations == ROT_CNT_W'(ROTATIONS_PER_READ - 1))
                    || timer == TRACK_CNT_W'(TRACK_TIMEOUT_CYCLES - 1)) begin
                    busy       <= 1'b0;
                    probe.done <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tallies, cleared by start and frozen between reads
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (probe.start) begin
            probe.match_count <= '0;
            probe.min_sector  <= '1;  // Any sector number is lower
            probe.max_sector  <= '0;
        end else if (busy && header_hit) begin
            if (probe.match_count != '1)
                probe.match_count <= probe.match_count + 1'b1;
            if (sector_number < probe.min_sector)
                probe.min_sector <= sector_number;
            if (sector_number > probe.max_sector)
                probe.max_sector <= sector_number;
        end
    end

    // Sequencer keeps one read outstanding
    assert property (@(posedge clk) disable iff (reset) probe.start |-> !busy)
        else $error("track read started while one is running");

endmodule

`default_nettype wire

/* hdl/scan_sequencer.sv */
// Stage FSM for head scan, sectors-per-track scan and cylinder binary search, holds results
`default_nettype none

module scan_sequencer import geo_scan_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             scan_start,
    input  logic             scan_abort,
    input  logic             drive_ready,
    input  logic             drive_fault,
    position_if.sequencer    pos,
    track_probe_if.sequencer probe,
    output logic             scan_done,
    output logic             scan_busy,
    output scan_stage_e      scan_stage,
    output head_count_t      num_heads,
    output cylinder_t        num_cylinders,
    output sector_t          sectors_per_track,
    output logic             geometry_valid
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_POS,        // Issue position request
        SEQ_POS_WAIT,
        SEQ_READ,       // Issue track read
        SEQ_READ_WAIT,  // Results used on done
        SEQ_STEP,       // Next binary search probe
        SEQ_FINISH
    } seq_state_e;

    seq_state_e  state;
    cylinder_t   probe_cyl;   // Target of current probe
    head_t       probe_head;
    cylinder_t   cyl_low;     // Highest cylinder known good
    cylinder_t   cyl_high;    // Lowest cylinder known bad
    logic        pos_open;    // Position request in flight
    logic        read_open;   // Track read in flight
    logic        head_found;
    head_count_t heads_next;

    assign pos.cylinder   = probe_cyl;
    assign pos.head       = probe_head;
    assign probe.cylinder = probe_cyl;
    assign probe.head     = probe_head;

    assign head_found = (probe.match_count != '0);
    assign heads_next = num_heads + head_count_t'(head_found);

    // ----------------------------------------------------------------------
    // Outstanding work, may outlive an aborted scan
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pos_open  <= 1'b0;
            read_open <= 1'b0;
        end else begin
            if (pos.req)
                pos_open <= 1'b1;
            else if (pos.done)
                pos_open <= 1'b0;
            if (probe.start)
                read_open <= 1'b1;
            else if (probe.done)
                read_open <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Stage FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= SEQ_IDLE;
            scan_stage        <= STAGE_IDLE;
            scan_done         <= 1'b0;
            scan_busy         <= 1'b0;
            geometry_valid    <= 1'b0;
            pos.req           <= 1'b0;
            probe.start       <= 1'b0;
            probe_cyl         <= '0;
            probe_head        <= '0;
            cyl_low           <= '0;
            cyl_high          <= MAX_CYLINDERS;
            num_heads         <= '0;
            num_cylinders     <= '0;
            sectors_per_track <= '0;
        end else begin
            scan_done   <= 1'b0;
            pos.req     <= 1'b0;
            probe.start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (scan_start && drive_ready && !drive_fault) begin
                        scan_busy      <= 1'b1;
                        geometry_valid <= 1'b0;
                        scan_stage     <= STAGE_HEAD_SCAN;
                        num_heads      <= '0;
                        probe_cyl      <= '0;  // Heads are probed on cylinder 0
                        probe_head     <= '0;
                        state          <= SEQ_POS;
                    end
                end
                SEQ_POS: begin
                    if (!pos_open) begin  // Drain a leftover from an abort
                        pos.req <= 1'b1;
                        state   <= SEQ_POS_WAIT;
                    end
                end
                SEQ_POS_WAIT: begin
                    if (pos.done) begin
                        if (!pos.error) begin
                            state <= SEQ_READ;
                        end else if (scan_stage == STAGE_CYL_SEARCH) begin
                            cyl_high <= probe_cyl;  // Past the last cylinder
                            state    <= SEQ_STEP;
                        end else begin
                            scan_stage <= STAGE_ERROR;
                            state      <= SEQ_FINISH;
                        end
                    end
                end
                SEQ_READ: begin
                    if (!read_open) begin
                        probe.start <= 1'b1;
                        state       <= SEQ_READ_WAIT;
                    end
                end
                SEQ_READ_WAIT: begin
                    if (probe.done) begin
                        state <= SEQ_POS;
                        case (scan_stage)
                            STAGE_HEAD_SCAN: begin
                                num_heads  <= heads_next;
                                probe_head <= probe_head + head_t'(1);  // Wraps to 0 for SPT
                                if (probe_head == head_t'(MAX_HEADS - 1)) begin
                                    if (heads_next == '0) begin
                                        scan_stage <= STAGE_ERROR;  // No head answered
                                        state      <= SEQ_FINISH;
                                    end else begin
                                        scan_stage <= STAGE_SPT_SCAN;
                                    end
                                end
                            end
                            STAGE_SPT_SCAN: begin
                                // 0-based numbering needs one more
                                sectors_per_track <= (probe.min_sector == '0)
                                                     ? probe.max_sector + sector_t'(1)
                                                     : probe.max_sector;
                                scan_stage <= STAGE_CYL_SEARCH;
                                cyl_low    <= '0;
                                cyl_high   <= MAX_CYLINDERS;
                                state      <= SEQ_STEP;
                            end
                            default: begin
                                if (head_found)
                                    cyl_low <= probe_cyl;
                                else
                                    cyl_high <= probe_cyl;
                                state <= SEQ_STEP;
                            end
                        endcase
                    end
                end
                SEQ_STEP: begin
                    if (cyl_high - cyl_low > cylinder_t'(1)) begin
                        probe_cyl <= (cyl_low + cyl_high) >> 1;  // Midpoint
                        state     <= SEQ_POS;
                    end else begin
                        num_cylinders  <= cyl_low + cylinder_t'(1);
                        geometry_valid <= 1'b1;
                        scan_stage     <= STAGE_COMPLETE;
                        state          <= SEQ_FINISH;
                    end
                end
                SEQ_FINISH: begin
                    scan_done <= 1'b1;  // Busy drops on the same edge
                    scan_busy <= 1'b0;
                    state     <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase

            // Abort wins over any step in progress
            if (scan_abort && scan_busy && state != SEQ_FINISH) begin
                scan_stage     <= STAGE_IDLE;
                geometry_valid <= 1'b0;
                state          <= SEQ_FINISH;
            end
        end
    end

    // Positioner answers only a request that is still open
    assert property (@(posedge clk) disable iff (reset) pos.done |-> pos_open)
        else $error("position done without an open request");

endmodule

`default_nettype wire

/* hdl/geometry_scanner.sv */
// Drive geometry scanner top, ties the sequencer to the positioner and the track reader
`default_nettype none

module geometry_scanner import geo_scan_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Host control
    input  logic        scan_start,
    input  logic        scan_abort,
    output logic        scan_done,
    output logic        scan_busy,
    output scan_stage_e scan_stage,

    // Seek controller and head select
    output logic        seek_start,
    output cylinder_t   seek_cylinder,
    input  logic        seek_done,
    input  logic        seek_error,
    output head_t       head_select,

    // Decoded header stream
    input  logic        sector_header_valid,
    input  cylinder_t   sector_cylinder,
    input  head_t       sector_head,
    input  sector_t     sector_number,
    input  logic        sector_crc_ok,
    input  logic        index_pulse,

    // Drive status
    input  logic        drive_ready,
    input  logic        drive_fault,

    // Results
    output head_count_t num_heads,
    output cylinder_t   num_cylinders,
    output sector_t     sectors_per_track,
    output logic        geometry_valid
);

    position_if    pos_bus ();
    track_probe_if probe_bus ();

    scan_sequencer i_sequencer (
        .clk, .reset, .scan_start, .scan_abort, .drive_ready, .drive_fault,
        .pos   (pos_bus.sequencer),
        .probe (probe_bus.sequencer),
        .scan_done, .scan_busy, .scan_stage,
        .num_heads, .num_cylinders, .sectors_per_track, .geometry_valid
    );

    head_positioner i_positioner (
        .clk, .reset,
        .pos (pos_bus.positioner),
        .seek_start, .seek_cylinder, .head_select, .seek_done, .seek_error
    );

    track_reader i_reader (
        .clk, .reset,
        .probe (probe_bus.reader),
        .sector_header_valid, .sector_crc_ok, .sector_cylinder, .sector_head,
        .sector_number, .index_pulse
    );

endmodule

`default_nettype wire

/* bench/drive_model.sv */
// Behavioural MFM/RLL drive for the testbench, answers seeks and streams index and headers
`default_nettype none

module drive_model import geo_scan_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Geometry of the simulated drive
    input  head_count_t cfg_heads,
    input  cylinder_t   cfg_cylinders,
    input  sector_t     cfg_spt,
    input  logic        cfg_first,      // First sector number, 0 or 1

    // Seek controller side
    input  logic        seek_start,
    input  cylinder_t   seek_cylinder,
    input  head_t       head_select,
    output logic        seek_done,
    output logic        seek_error,

    // Read channel
    output logic        sector_header_valid,
    output cylinder_t   sector_cylinder,
    output head_t       sector_head,
    output sector_t     sector_number,
    output logic        sector_crc_ok,
    output logic        index_pulse
);
    timeunit 1ns;
    timeprecision 1ps;

    int        seek_wait;   // Cycles left on the running seek, 0 when idle
    cylinder_t target_cyl;
    cylinder_t cur_cyl;     // Cylinder under the heads
    int        tick;        // 8 cycles per sector slot
    sector_t   slot;        // Slot within the rotation

    initial begin
        seek_done           = 1'b0;
        seek_error          = 1'b0;
        sector_header_valid = 1'b0;
        sector_cylinder     = '0;
        sector_head         = '0;
        sector_number       = '0;
        sector_crc_ok       = 1'b0;
        index_pulse         = 1'b0;
    end

    // Everything changes on the falling edge, away from the DUT's sampling edge
    always @(negedge clk) begin
        if (reset) begin
            seek_wait           <= 0;
            target_cyl          <= '0;
            cur_cyl             <= '0;
            tick                <= 0;
            slot                <= '0;
            seek_done           <= 1'b0;
            seek_error          <= 1'b0;
            sector_header_valid <= 1'b0;
            index_pulse         <= 1'b0;
        end else begin
            seek_done           <= 1'b0;
            seek_error          <= 1'b0;
            sector_header_valid <= 1'b0;
            index_pulse         <= 1'b0;

            // -----------------------------------------------------------------
            // Seek mechanics
            // -----------------------------------------------------------------
            if (seek_start && seek_wait == 0) begin
                seek_wait  <= $urandom_range(40, 1);  // Random arm travel
                target_cyl <= seek_cylinder;
            end else if (seek_wait != 0) begin
                seek_wait <= seek_wait - 1;
                if (seek_wait == 1) begin
                    if (target_cyl >= cfg_cylinders) begin
                        seek_error <= 1'b1;  // Past the last cylinder
                    end else begin
                        seek_done <= 1'b1;
                        cur_cyl   <= target_cyl;
                    end
                end
            end

            // Spindle keeps turning, headers only when the arm is still
            if (tick == 7) begin
                tick <= 0;
                slot <= (slot + 8'd1 >= cfg_spt) ? '0 : slot + 8'd1;
            end else begin
                tick <= tick + 1;
            end
            if (tick == 0) begin
                index_pulse <= (slot == '0);  // One pulse per rotation
                if (seek_wait == 0 && head_count_t'(head_select) < cfg_heads) begin
                    sector_header_valid <= 1'b1;
                    sector_cylinder     <= cur_cyl;
                    sector_head         <= head_select;
                    sector_number       <= slot + sector_t'(cfg_first);
                    sector_crc_ok       <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_geometry_scanner.sv */
// Testbench top, runs a table of drive geometries through the scanner and checks the results
`default_nettype none

module tb_geometry_scanner import geo_scan_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS    = 7;
    localparam int CYCLE_LIMIT = NUM_ROWS * 40000;  // Worst scan is well under 40k

    // One scan per row
    typedef struct packed {
        head_count_t heads;
        cylinder_t   cyls;
        sector_t     spt;
        logic        first;        // First sector number
        logic        ready;
        logic        fault;
        logic [15:0] abort_after;  // Cycles into the scan, 0 for none
        logic        exp_start;    // Scan expected to run at all
        logic        exp_valid;
        scan_stage_e exp_stage;
        head_count_t exp_heads;
        cylinder_t   exp_cyls;
        sector_t     exp_spt;
    } scan_row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        scan_start, scan_abort, scan_done, scan_busy;
    scan_stage_e scan_stage;
    logic        seek_start, seek_done, seek_error;
    cylinder_t   seek_cylinder;
    head_t       head_select;
    logic        sector_header_valid, sector_crc_ok, index_pulse;
    cylinder_t   sector_cylinder;
    head_t       sector_head;
    sector_t     sector_number;
    logic        drive_ready, drive_fault;
    head_count_t num_heads;
    cylinder_t   num_cylinders;
    sector_t     sectors_per_track;
    logic        geometry_valid;

    // Drive configuration
    head_count_t cfg_heads;
    cylinder_t   cfg_cylinders;
    sector_t     cfg_spt;
    logic        cfg_first;

    scan_row_t rows [NUM_ROWS];
    int        row_idx;
    int        cycles = 0;

    always #2 clk = ~clk;  // 4 ns period

    geometry_scanner i_dut (.*);

    drive_model i_drive (.*);

    // -----------------------------------------------------------------------
    // Helpers
    // -----------------------------------------------------------------------
    function automatic scan_row_t make_row(
        input int heads, input int cyls, input int spt, input int first,
        input int ready, input int fault, input int abort_after,
        input int exp_start, input int exp_valid, input scan_stage_e exp_stage,
        input int exp_heads, input int exp_cyls, input int exp_spt
    );
        scan_row_t r;
        r.heads       = head_count_t'(heads);
        r.cyls        = cylinder_t'(cyls);
        r.spt         = sector_t'(spt);
        r.first       = first[0];
        r.ready       = ready[0];
        r.fault       = fault[0];
        r.abort_after = 16'(abort_after);
        r.exp_start   = exp_start[0];
        r.exp_valid   = exp_valid[0];
        r.exp_stage   = exp_stage;
        r.exp_heads   = head_count_t'(exp_heads);
        r.exp_cyls    = cylinder_t'(exp_cyls);
        r.exp_spt     = sector_t'(exp_spt);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] row %0d %s: got 0x%0h, expected 0x%0h",
                     row_idx, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic run_row(input scan_row_t r);
        int waited;
        cfg_heads     = r.heads;  // Inputs move on the falling edge
        cfg_cylinders = r.cyls;
        cfg_spt       = r.spt;
        cfg_first     = r.first;
        drive_ready   = r.ready;
        drive_fault   = r.fault;
        @(negedge clk);
        scan_start = 1'b1;
        @(negedge clk);
        scan_start = 1'b0;
        if (!r.exp_start) begin
            repeat (100) begin  // Start must be ignored
                check_value("scan_busy", scan_busy, 0);
                check_value("scan_done", scan_done, 0);
                @(negedge clk);
            end
        end else begin
            check_value("scan_busy", scan_busy, 1);
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                scan_abort = (r.abort_after != 0 && waited == r.abort_after);
                if (scan_abort)
                    check_value("scan_stage", scan_stage, STAGE_HEAD_SCAN);  // Mid head scan
            end while (!scan_done);
            scan_abort = 1'b0;
            check_value("scan_busy", scan_busy, 0);  // Falls with done
            check_value("geometry_valid", geometry_valid, r.exp_valid);
            check_value("scan_stage", scan_stage, r.exp_stage);
            if (r.exp_valid) begin
                check_value("num_heads", num_heads, r.exp_heads);
                check_value("num_cylinders", num_cylinders, r.exp_cyls);
                check_value("sectors_per_track", sectors_per_track, r.exp_spt);
            end
            @(negedge clk);
            check_value("scan_done", scan_done, 0);  // Single pulse
        end
        drive_ready = 1'b0;
        repeat (50) @(negedge clk);  // Gap between rows
    endtask

    // -----------------------------------------------------------------------
    // Watchdog
    // -----------------------------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the scans did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "watchdog expired");
        end
    end

    // -----------------------------------------------------------------------
    // Main sequence
    // -----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h5ce6dad2));
        reset         = 1'b1;
        scan_start    = 1'b0;
        scan_abort    = 1'b0;
        drive_ready   = 1'b0;
        drive_fault   = 1'b0;
        cfg_heads     = '0;
        cfg_cylinders = '0;
        cfg_spt       = 8'd17;
        cfg_first     = 1'b1;
        row_idx       = 0;

        //                 hd  cyl  spt 1st rdy flt abort go val stage          heads cyl spt
        rows[0] = make_row(4,  615, 17, 1, 1, 0, 0,  1, 1, STAGE_COMPLETE, 4, 615, 17);
        rows[1] = make_row(16, 4096, 26, 0, 1, 0, 0, 1, 1, STAGE_COMPLETE, 16, 4096, 26);
        rows[2] = make_row(2,  1,   17, 1, 1, 0, 0,  1, 1, STAGE_COMPLETE, 2, 1, 17);
        rows[3] = make_row(4,  615, 17, 1, 0, 0, 0,  0, 0, STAGE_IDLE, 0, 0, 0);  // Not ready
        rows[4] = make_row(4,  615, 17, 1, 1, 1, 0,  0, 0, STAGE_IDLE, 0, 0, 0);  // Fault
        rows[5] = make_row(4,  615, 17, 1, 1, 0, 300, 1, 0, STAGE_IDLE, 0, 0, 0);
        rows[6] = make_row(0,  100, 17, 1, 1, 0, 0,  1, 0, STAGE_ERROR, 0, 0, 0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet outputs straight out of reset
        check_value("scan_busy", scan_busy, 0);
        check_value("scan_done", scan_done, 0);
        check_value("seek_start", seek_start, 0);
        check_value("geometry_valid", geometry_valid, 0);
        check_value("scan_stage", scan_stage, STAGE_IDLE);
        repeat (5) @(negedge clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row_idx = i;
            run_row(rows[i]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* geometry_scanner.f */
hdl/geo_scan_pkg.sv
hdl/position_if.sv
hdl/track_probe_if.sv
hdl/head_positioner.sv
hdl/track_reader.sv
hdl/scan_sequencer.sv
hdl/geometry_scanner.sv
bench/drive_model.sv
bench/tb_geometry_scanner.sv

/* Bender.yml */
package:
  name: geometry_scanner

sources:
  - hdl/geo_scan_pkg.sv
  - hdl/position_if.sv
  - hdl/track_probe_if.sv
  - hdl/head_positioner.sv
  - hdl/track_reader.sv
  - hdl/scan_sequencer.sv
  - hdl/geometry_scanner.sv
  - target: test
    files:
      - bench/drive_model.sv
      - bench/tb_geometry_scanner.sv
